//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert \
  --top-module tb_cache_response \
  -Mdir obj_dir \
  -f sim.f \
  > build.log 2>&1 \
  && ./obj_dir/Vtb_cache_response > sim.log 2>&1 \
  || echo "build or simulation exited with an error, see build.log and sim.log"

# Pass only when the exact pass line is in the simulation log
grep -qx "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  && exit 0 \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
verilog/glay_cache_pkg.sv
verilog/reset_busy_timer.sv
verilog/response_control_fsm.sv
verilog/response_fifo.sv
verilog/response_router.sv
verilog/cache_response_top.sv
verif/tb_cache_response.sv

//--- verif/tb_cache_response.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_response;

  localparam int fifo_depth        = 32;
  localparam int prog_thresh       = 16;
  localparam int reset_busy_cycles = 8;

  // Response counts per test
  localparam int n_route     = 60;
  localparam int n_order     = 100;
  localparam int n_bp_max    = 40;
  localparam int n_total     = n_route + n_order + n_bp_max;
  localparam int wd_cycles   = n_total * 40 + 2000;
  localparam int drain_limit = 2000;

  // Expected response with fields in stored word order
  typedef struct packed {
    logic [glay_cache_pkg::addr_w-1:0]  addr;
    logic [glay_cache_pkg::route_w-1:0] route;
    glay_cache_pkg::buffer_kind_t       kind;
    glay_cache_pkg::cmd_t               cmd;
    logic [glay_cache_pkg::data_w-1:0]  data;
  } resp_t;

  logic                               ap_clk = 1'b0;
  logic                               areset_control;
  logic                               in_valid;
  logic                               in_ready;
  logic [glay_cache_pkg::addr_w-1:0]  in_addr;
  logic [glay_cache_pkg::route_w-1:0] in_route;
  glay_cache_pkg::buffer_kind_t       in_kind;
  logic [glay_cache_pkg::data_w-1:0]  in_data;
  logic                               ctrl_valid;
  logic                               ctrl_ready;
  logic [glay_cache_pkg::addr_w-1:0]  ctrl_addr;
  logic [glay_cache_pkg::route_w-1:0] ctrl_route;
  glay_cache_pkg::buffer_kind_t       ctrl_kind;
  glay_cache_pkg::cmd_t               ctrl_cmd;
  logic [glay_cache_pkg::data_w-1:0]  ctrl_data;
  logic                               eng_valid;
  logic                               eng_ready;
  logic [glay_cache_pkg::addr_w-1:0]  eng_addr;
  logic [glay_cache_pkg::route_w-1:0] eng_route;
  glay_cache_pkg::buffer_kind_t       eng_kind;
  glay_cache_pkg::cmd_t               eng_cmd;
  logic [glay_cache_pkg::data_w-1:0]  eng_data;
  logic                               setup_busy;

  // Model queues per port
  resp_t ctrl_q[$];
  resp_t eng_q[$];

  // 0 both ready, 1 random, 2 both stalled
  int ready_mode   = 0;
  int errors       = 0;
  int stab_errors  = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int n_setup      = 0;
  int n_flush      = 0;
  int n_other      = 0;
  int ctrl_count   = 0;
  int eng_count    = 0;

  cache_response_top #(
    .fifo_depth       (fifo_depth),
    .prog_thresh      (prog_thresh),
    .reset_busy_cycles(reset_busy_cycles)
  ) UUT (
    .ap_clk(ap_clk), .areset_control(areset_control),
    .in_valid(in_valid), .in_ready(in_ready), .in_addr(in_addr),
    .in_route(in_route), .in_kind(in_kind), .in_data(in_data),
    .ctrl_valid(ctrl_valid), .ctrl_ready(ctrl_ready), .ctrl_addr(ctrl_addr),
    .ctrl_route(ctrl_route), .ctrl_kind(ctrl_kind), .ctrl_cmd(ctrl_cmd),
    .ctrl_data(ctrl_data),
    .eng_valid(eng_valid), .eng_ready(eng_ready), .eng_addr(eng_addr),
    .eng_route(eng_route), .eng_kind(eng_kind), .eng_cmd(eng_cmd),
    .eng_data(eng_data),
    .setup_busy(setup_busy)
  );

  always #20 ap_clk = ~ap_clk;

  // ----------------------------------------------------------------------
  // Check and report helpers
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_resp(input string port, input resp_t got, input resp_t exp);
    check_value({port, "_addr"}, 64'(got.addr), 64'(exp.addr));
    check_value({port, "_route"}, 64'(got.route), 64'(exp.route));
    check_value({port, "_kind"}, 64'(got.kind), 64'(exp.kind));
    check_value({port, "_cmd"}, 64'(got.cmd), 64'(exp.cmd));
    check_value({port, "_data"}, 64'(got.data), 64'(exp.data));
  endtask

  task automatic report_test(input string name, input int new_errors);
    if (new_errors == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, new_errors);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  // Readies picked at the edge and applied 2 ns later
  always @(posedge ap_clk) begin : ready_drive
    logic [31:0] rnd;
    int          mode;
    rnd  = $urandom();
    mode = ready_mode;
    #2;
    case (mode)
      0: begin
        ctrl_ready = 1'b1;
        eng_ready  = 1'b1;
      end
      1: begin
        ctrl_ready = rnd[0];
        eng_ready  = rnd[1];
      end
      default: begin
        ctrl_ready = 1'b0;
        eng_ready  = 1'b0;
      end
    endcase
  end

  task automatic drive_item();
    logic [31:0] rnd;
    rnd      = $urandom();
    in_valid = 1'b1;
    in_addr  = $urandom();
    in_route = rnd[glay_cache_pkg::route_w-1:0];
    in_kind  = glay_cache_pkg::buffer_kind_t'(rnd[9:8]);
    in_data  = $urandom();
  endtask

  // Held until the edge that takes it
  task automatic wait_accept();
    @(negedge ap_clk);
    while (!in_ready) @(negedge ap_clk);
    @(posedge ap_clk);
    #2;
  endtask

  task automatic send_responses(input int n);
    for (int i = 0; i < n; i++) begin
      // Occasional idle cycle
      if ($urandom_range(3, 0) == 0) begin
        in_valid = 1'b0;
        @(posedge ap_clk);
        #2;
      end
      drive_item();
      wait_accept();
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while ((ctrl_q.size() != 0 || eng_q.size() != 0) && waited < drain_limit) begin
      @(posedge ap_clk);
      #2;
      waited++;
    end
    if (ctrl_q.size() != 0 || eng_q.size() != 0) begin
      $display("%s: responses still queued after %0d cycles", what, waited);
      errors++;
    end
    repeat (3) @(posedge ap_clk);
    #2;
  endtask

  // Stall both ports until the input side stops accepting
  task automatic run_backpressure();
    int low_run;
    int sent;
    bit bp_seen;
    sent       = 0;
    bp_seen    = 1'b0;
    ready_mode = 2;
    while (!bp_seen && sent < n_bp_max) begin
      drive_item();
      low_run = 0;
      @(negedge ap_clk);
      while (!in_ready && low_run < 10) begin
        low_run++;
        @(negedge ap_clk);
      end
      if (!in_ready) begin
        bp_seen = 1'b1;
      end else begin
        @(posedge ap_clk);
        #2;
        sent++;
      end
    end
    if (!bp_seen) begin
      $display("in_ready never fell while both output readies were low");
      errors++;
    end
    // Pending item goes in once the ports drain
    ready_mode = 0;
    if (in_valid) wait_accept();
    in_valid = 1'b0;
    wait_drain("backpressure");
  endtask

  // ----------------------------------------------------------------------
  // Model and monitor sampled mid-cycle
  // ----------------------------------------------------------------------
  resp_t prev_ctrl;
  resp_t prev_eng;
  bit    ctrl_wait = 1'b0;
  bit    eng_wait  = 1'b0;

  always @(negedge ap_clk) begin : monitor
    resp_t item;
    resp_t got_c;
    resp_t got_e;
    int    snap;
    got_c = '{ctrl_addr, ctrl_route, ctrl_kind, ctrl_cmd, ctrl_data};
    got_e = '{eng_addr, eng_route, eng_kind, eng_cmd, eng_data};
    if (areset_control) begin
      ctrl_wait = 1'b0;
      eng_wait  = 1'b0;
    end else begin
      // Input transfer happens on the coming edge
      if (in_valid && in_ready) begin
        item = '{in_addr, in_route, in_kind, glay_cache_pkg::cmd_mem_response, in_data};
        case (in_kind)
          glay_cache_pkg::buf_setup: begin
            ctrl_q.push_back(item);
            eng_q.push_back(item);
            n_setup++;
          end
          glay_cache_pkg::buf_flush: begin
            ctrl_q.push_back(item);
            n_flush++;
          end
          default: begin
            eng_q.push_back(item);
            n_other++;
          end
        endcase
      end
      // Held outputs must not move while waiting
      snap = errors;
      if (ctrl_wait) begin
        check_value("ctrl_valid", 64'(ctrl_valid), 64'd1);
        compare_resp("ctrl_held", got_c, prev_ctrl);
      end
      if (eng_wait) begin
        check_value("eng_valid", 64'(eng_valid), 64'd1);
        compare_resp("eng_held", got_e, prev_eng);
      end
      stab_errors += errors - snap;
      ctrl_wait = ctrl_valid && !ctrl_ready;
      eng_wait  = eng_valid && !eng_ready;
      prev_ctrl = got_c;
      prev_eng  = got_e;
      // Output handshakes against the model
      if (ctrl_valid && ctrl_ready) begin
        ctrl_count++;
        if (ctrl_q.size() == 0) begin
          $display("ctrl port delivered a response that was never sent to it");
          errors++;
        end else begin
          compare_resp("ctrl", got_c, ctrl_q.pop_front());
        end
      end
      if (eng_valid && eng_ready) begin
        eng_count++;
        if (eng_q.size() == 0) begin
          $display("eng port delivered a response that was never sent to it");
          errors++;
        end else begin
          compare_resp("eng", got_e, eng_q.pop_front());
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------
  initial begin
    repeat (wd_cycles) @(posedge ap_clk);
    $display("watchdog expired after %0d clock cycles, the run did not finish", wd_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int e0;
    int cycles;
    void'($urandom(27));
    areset_control = 1'b1;
    in_valid       = 1'b0;
    in_addr        = '0;
    in_route       = '0;
    in_kind        = glay_cache_pkg::buf_setup;
    in_data        = '0;
    ctrl_ready     = 1'b0;
    eng_ready      = 1'b0;

    // Reset and setup window
    e0 = errors;
    repeat (4) @(posedge ap_clk);
    #2;
    areset_control = 1'b0;
    @(negedge ap_clk);
    check_value("setup_busy", 64'(setup_busy), 64'd1);
    check_value("in_ready", 64'(in_ready), 64'd0);
    check_value("ctrl_valid", 64'(ctrl_valid), 64'd0);
    check_value("eng_valid", 64'(eng_valid), 64'd0);
    cycles = 0;
    while (setup_busy && cycles < 30) begin
      // Input stays closed for the whole window
      check_value("in_ready", 64'(in_ready), 64'd0);
      @(negedge ap_clk);
      cycles++;
    end
    if (cycles < reset_busy_cycles - 2 || cycles > reset_busy_cycles + 2) begin
      $display("setup_busy fell after %0d cycles, outside the expected window", cycles);
      errors++;
    end
    // Empty FIFO lets the input open right away
    check_value("in_ready", 64'(in_ready), 64'd1);
    @(posedge ap_clk);
    #2;
    report_test("reset_window", errors - e0);

    // Routing with both ports always ready
    e0         = errors;
    ready_mode = 0;
    send_responses(n_route);
    wait_drain("routing");
    report_test("routing", errors - e0);

    // Per-port order under random readies
    e0         = errors;
    ready_mode = 1;
    send_responses(n_order);
    ready_mode = 0;
    wait_drain("port_order");
    report_test("port_order", errors - e0);

    e0 = errors;
    run_backpressure();
    report_test("backpressure", errors - e0);

    report_test("output_stability", stab_errors);

    // Delivered counts follow the routing rule
    e0 = errors;
    check_value("ctrl_queue_left", 64'(ctrl_q.size()), 64'd0);
    check_value("eng_queue_left", 64'(eng_q.size()), 64'd0);
    check_value("ctrl_count", 64'(ctrl_count), 64'(n_setup + n_flush));
    check_value("eng_count", 64'(eng_count), 64'(n_setup + n_other));
    report_test("drain_counts", errors - e0);

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/cache_response_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_response_top #(
  parameter int fifo_depth        = 32,
  parameter int prog_thresh       = 16,
  parameter int reset_busy_cycles = 8
) (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               in_valid,
  output logic                               in_ready,
  input  logic [glay_cache_pkg::addr_w-1:0]  in_addr,
  input  logic [glay_cache_pkg::route_w-1:0] in_route,
  input  glay_cache_pkg::buffer_kind_t       in_kind,
  input  logic [glay_cache_pkg::data_w-1:0]  in_data,
  output logic                               ctrl_valid,
  input  logic                               ctrl_ready,
  output logic [glay_cache_pkg::addr_w-1:0]  ctrl_addr,
  output logic [glay_cache_pkg::route_w-1:0] ctrl_route,
  output glay_cache_pkg::buffer_kind_t       ctrl_kind,
  output glay_cache_pkg::cmd_t               ctrl_cmd,
  output logic [glay_cache_pkg::data_w-1:0]  ctrl_data,
  output logic                               eng_valid,
  input  logic                               eng_ready,
  output logic [glay_cache_pkg::addr_w-1:0]  eng_addr,
  output logic [glay_cache_pkg::route_w-1:0] eng_route,
  output glay_cache_pkg::buffer_kind_t       eng_kind,
  output glay_cache_pkg::cmd_t               eng_cmd,
  output logic [glay_cache_pkg::data_w-1:0]  eng_data,
  output logic                               setup_busy
);

  // ----------------------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------------------
  logic                                busy_done;
  logic                                accept_en;
  logic                                fifo_pop;
  logic                                route_ready;
  logic                                push;
  logic [glay_cache_pkg::packet_w-1:0] push_data;
  logic                                head_valid;
  logic [glay_cache_pkg::packet_w-1:0] head_data;
  logic                                prog_full;

  // Setup window after reset
  reset_busy_timer #(
    .reset_busy_cycles(reset_busy_cycles)
  ) u_timer (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .busy_done     (busy_done)
  );

  // Sequencing of accept and pop
  response_control_fsm u_fsm (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .busy_done     (busy_done),
    .head_valid    (head_valid),
    .route_ready   (route_ready),
    .prog_full     (prog_full),
    .accept_en     (accept_en),
    .fifo_pop      (fifo_pop),
    .setup_busy    (setup_busy)
  );

  // Response queue
  response_fifo #(
    .fifo_depth (fifo_depth),
    .prog_thresh(prog_thresh)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push          (push),
    .push_data     (push_data),
    .pop           (fifo_pop),
    .head_valid    (head_valid),
    .full          (),
    .prog_full     (prog_full),
    .head_data     (head_data)
  );

  // Capture, rewrite and fan-out
  response_router u_router (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .accept_en     (accept_en),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_addr       (in_addr),
    .in_route      (in_route),
    .in_kind       (in_kind),
    .in_data       (in_data),
    .push          (push),
    .push_data     (push_data),
    .head_data     (head_data),
    .fifo_pop      (fifo_pop),
    .route_ready   (route_ready),
    .ctrl_valid    (ctrl_valid),
    .ctrl_ready    (ctrl_ready),
    .ctrl_addr     (ctrl_addr),
    .ctrl_route    (ctrl_route),
    .ctrl_kind     (ctrl_kind),
    .ctrl_cmd      (ctrl_cmd),
    .ctrl_data     (ctrl_data),
    .eng_valid     (eng_valid),
    .eng_ready     (eng_ready),
    .eng_addr      (eng_addr),
    .eng_route     (eng_route),
    .eng_kind      (eng_kind),
    .eng_cmd       (eng_cmd),
    .eng_data      (eng_data)
  );

endmodule

`default_nettype wire

//--- verilog/glay_cache_pkg.sv
`default_nettype none

package glay_cache_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int addr_w  = 32;
  localparam int data_w  = 32;
  localparam int route_w = 8;
  localparam int kind_w  = 2;
  localparam int cmd_w   = 2;

  // Target buffer of a response
  typedef enum logic [1:0] {
    buf_setup = 2'd0,
    buf_flush = 2'd1,
    buf_data  = 2'd2,
    buf_edge  = 2'd3
  } buffer_kind_t;

  // Command field, rewritten on the return path
  typedef enum logic [1:0] {
    cmd_mem_read     = 2'd0,
    cmd_mem_write    = 2'd1,
    cmd_mem_response = 2'd2
  } cmd_t;

  // ----------------------------------------------------------------------
  // Stored response word
  // ----------------------------------------------------------------------
  // Layout, MSB down to LSB
  //   addr | route | kind | cmd | data
  localparam int packet_w  = addr_w + route_w + kind_w + cmd_w + data_w;
  localparam int data_lsb  = 0;
  localparam int cmd_lsb   = data_lsb + data_w;
  localparam int kind_lsb  = cmd_lsb + cmd_w;
  localparam int route_lsb = kind_lsb + kind_w;
  localparam int addr_lsb  = route_lsb + route_w;

endpackage

`default_nettype wire

//--- verilog/reset_busy_timer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_busy_timer #(
  parameter int reset_busy_cycles = 8
) (
  input  logic ap_clk,
  input  logic areset_control,
  output logic busy_done
);

  // Counter wide enough for the full window, at least one bit
  localparam int cnt_w = (reset_busy_cycles > 0) ? $clog2(reset_busy_cycles + 1) : 1;

  logic [cnt_w-1:0] busy_cnt;

  // ----------------------------------------------------------------------
  // Countdown after reset
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      // Window restarts on every reset cycle
      busy_cnt <= cnt_w'(reset_busy_cycles);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // Counter parks at zero until the next reset
  assign busy_done = (busy_cnt == '0);

  // Done is sticky outside reset
  a_done_sticky : assert property (
    @(posedge ap_clk) busy_done && !areset_control |=> busy_done
  ) else $error("busy_done fell without reset");

endmodule

`default_nettype wire

//--- verilog/response_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module response_control_fsm (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic busy_done,
  input  logic head_valid,
  input  logic route_ready,
  input  logic prog_full,
  output logic accept_en,
  output logic fifo_pop,
  output logic setup_busy
);

  typedef enum logic [1:0] {
    st_recover = 2'd0,
    st_stream  = 2'd1,
    st_stall   = 2'd2
  } state_t;

  state_t state;
  state_t state_next;

  // ----------------------------------------------------------------------
  // State register
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= st_recover;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      st_recover: begin
        // Hold until the FIFO recovery window ends
        if (busy_done) begin
          state_next = st_stream;
        end
      end
      st_stream: begin
        // Head blocked by a busy port
        if (head_valid && !route_ready) begin
          state_next = st_stall;
        end
      end
      st_stall: begin
        // Leaves on the pop that frees the head
        if (route_ready) begin
          state_next = st_stream;
        end
      end
      default: begin
        state_next = st_recover;
      end
    endcase
  end

  // Outputs decoded from state
  assign setup_busy = (state == st_recover);
  assign accept_en  = (state != st_recover) && !prog_full;
  assign fifo_pop   = (state != st_recover) && head_valid && route_ready;

  // Pop only with a head present
  a_pop_needs_head : assert property (
    @(posedge ap_clk) disable iff (areset_control) fifo_pop |-> head_valid
  ) else $error("fifo_pop without head_valid");

  // A stalled head stays in the FIFO until popped
  a_stall_holds_head : assert property (
    @(posedge ap_clk) disable iff (areset_control) state == st_stall |-> head_valid
  ) else $error("head lost while stalled");

endmodule

`default_nettype wire

//--- verilog/response_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module response_fifo #(
  parameter int fifo_depth  = 32,
  parameter int prog_thresh = 16
) (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic                               push,
  input  logic [glay_cache_pkg::packet_w-1:0] push_data,
  input  logic                               pop,
  output logic                               head_valid,
  output logic                               full,
  output logic                               prog_full,
  output logic [glay_cache_pkg::packet_w-1:0] head_data
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  // Storage
  logic [glay_cache_pkg::packet_w-1:0] mem [fifo_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // ----------------------------------------------------------------------
  // Write side
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Flags and show-ahead head
  // ----------------------------------------------------------------------
  assign head_valid = (count != '0);
  assign full       = (count == cnt_w'(fifo_depth));
  assign prog_full  = (count >= cnt_w'(prog_thresh));
  assign head_data  = mem[rd_ptr];

  // Threshold must leave room for the in-flight response
  a_no_overflow : assert property (
    @(posedge ap_clk) disable iff (areset_control) push |-> !full
  ) else $error("push while FIFO full");

  a_no_underflow : assert property (
    @(posedge ap_clk) disable iff (areset_control) pop |-> head_valid
  ) else $error("pop while FIFO empty");

endmodule

`default_nettype wire

//--- verilog/response_router.sv
`timescale 1ns/1ps
`default_nettype none

module response_router (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                accept_en,
  input  logic                                in_valid,
  output logic                                in_ready,
  input  logic [glay_cache_pkg::addr_w-1:0]   in_addr,
  input  logic [glay_cache_pkg::route_w-1:0]  in_route,
  input  glay_cache_pkg::buffer_kind_t        in_kind,
  input  logic [glay_cache_pkg::data_w-1:0]   in_data,
  output logic                                push,
  output logic [glay_cache_pkg::packet_w-1:0] push_data,
  input  logic [glay_cache_pkg::packet_w-1:0] head_data,
  input  logic                                fifo_pop,
  output logic                                route_ready,
  output logic                                ctrl_valid,
  input  logic                                ctrl_ready,
  output logic [glay_cache_pkg::addr_w-1:0]   ctrl_addr,
  output logic [glay_cache_pkg::route_w-1:0]  ctrl_route,
  output glay_cache_pkg::buffer_kind_t        ctrl_kind,
  output glay_cache_pkg::cmd_t                ctrl_cmd,
  output logic [glay_cache_pkg::data_w-1:0]   ctrl_data,
  output logic                                eng_valid,
  input  logic                                eng_ready,
  output logic [glay_cache_pkg::addr_w-1:0]   eng_addr,
  output logic [glay_cache_pkg::route_w-1:0]  eng_route,
  output glay_cache_pkg::buffer_kind_t        eng_kind,
  output glay_cache_pkg::cmd_t                eng_cmd,
  output logic [glay_cache_pkg::data_w-1:0]   eng_data
);

  // Port index 0 is ctrl, 1 is eng
  localparam int n_ports = 2;

  logic                                in_reg_valid;
  logic [glay_cache_pkg::packet_w-1:0] in_reg_pkt;
  glay_cache_pkg::buffer_kind_t        head_kind;
  logic [n_ports-1:0]                  port_tgt;
  logic [n_ports-1:0]                  port_ready;
  logic [n_ports-1:0]                  port_free;
  logic [n_ports-1:0]                  port_valid;
  logic [glay_cache_pkg::packet_w-1:0] port_pkt [n_ports];

  // ----------------------------------------------------------------------
  // Input register and command rewrite
  // ----------------------------------------------------------------------
  assign in_ready = accept_en;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_reg_valid <= 1'b0;
    end else begin
      in_reg_valid <= in_valid && in_ready;
    end
  end

  // Stamp the memory-response code on capture
  always_ff @(posedge ap_clk) begin
    if (in_valid && in_ready) begin
      in_reg_pkt <= {in_addr, in_route, in_kind, glay_cache_pkg::cmd_mem_response, in_data};
    end
  end

  assign push      = in_reg_valid;
  assign push_data = in_reg_pkt;

  // ----------------------------------------------------------------------
  // Head decode
  // ----------------------------------------------------------------------
  assign head_kind = glay_cache_pkg::buffer_kind_t'(
    head_data[glay_cache_pkg::kind_lsb +: glay_cache_pkg::kind_w]);

  // Setup to both, flush to ctrl, the rest to eng
  assign port_tgt[0] = (head_kind == glay_cache_pkg::buf_setup) ||
                       (head_kind == glay_cache_pkg::buf_flush);
  assign port_tgt[1] = (head_kind != glay_cache_pkg::buf_flush);

  assign port_ready = {eng_ready, ctrl_ready};
  // Empty, or emptied on this edge
  assign port_free  = ~port_valid | port_ready;

  // Every targeted port must accept in the same pop
  assign route_ready = &(port_free | ~port_tgt);

  // ----------------------------------------------------------------------
  // Output holding registers
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    for (int p = 0; p < n_ports; p++) begin
      if (areset_control) begin
        port_valid[p] <= 1'b0;
      end else if (fifo_pop && port_tgt[p]) begin
        port_valid[p] <= 1'b1;
      end else if (port_ready[p]) begin
        port_valid[p] <= 1'b0;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int p = 0; p < n_ports; p++) begin
      if (fifo_pop && port_tgt[p]) begin
        port_pkt[p] <= head_data;
      end
    end
  end

  // Field slices
  assign ctrl_valid = port_valid[0];
  assign ctrl_addr  = port_pkt[0][glay_cache_pkg::addr_lsb +: glay_cache_pkg::addr_w];
  assign ctrl_route = port_pkt[0][glay_cache_pkg::route_lsb +: glay_cache_pkg::route_w];
  assign ctrl_kind  = glay_cache_pkg::buffer_kind_t'(
    port_pkt[0][glay_cache_pkg::kind_lsb +: glay_cache_pkg::kind_w]);
  assign ctrl_cmd   = glay_cache_pkg::cmd_t'(
    port_pkt[0][glay_cache_pkg::cmd_lsb +: glay_cache_pkg::cmd_w]);
  assign ctrl_data  = port_pkt[0][glay_cache_pkg::data_lsb +: glay_cache_pkg::data_w];

  assign eng_valid = port_valid[1];
  assign eng_addr  = port_pkt[1][glay_cache_pkg::addr_lsb +: glay_cache_pkg::addr_w];
  assign eng_route = port_pkt[1][glay_cache_pkg::route_lsb +: glay_cache_pkg::route_w];
  assign eng_kind  = glay_cache_pkg::buffer_kind_t'(
    port_pkt[1][glay_cache_pkg::kind_lsb +: glay_cache_pkg::kind_w]);
  assign eng_cmd   = glay_cache_pkg::cmd_t'(
    port_pkt[1][glay_cache_pkg::cmd_lsb +: glay_cache_pkg::cmd_w]);
  assign eng_data  = port_pkt[1][glay_cache_pkg::data_lsb +: glay_cache_pkg::data_w];

  // Held response is not replaced before its handshake
  for (genvar p = 0; p < n_ports; p++) begin : g_hold_chk
    a_port_hold : assert property (
      @(posedge ap_clk) disable iff (areset_control)
      port_valid[p] && !port_ready[p] |=> port_valid[p] && $stable(port_pkt[p])
    ) else $error("port %0d changed while waiting for ready", p);
  end

endmodule

`default_nettype wire
